//--- common/mips_pkg.sv
package mips_pkg;

    // data word, also used for the pc
    typedef logic [31:0] word_t;

    // architectural register index
    typedef logic [4:0] reg_addr_t;

    // register 0 is hardwired to zero
    localparam reg_addr_t reg_zero = 5'd0;

    typedef enum logic [2:0]
    {
        class_alu,
        class_load,
        class_store,
        class_branch,
        class_muldiv
    } instr_class_t;

    // one decoded instruction as it sits in the issue queue
    typedef struct packed
    {
        word_t        pc;
        instr_class_t iclass;
        logic         regwrite;
        reg_addr_t    dest;
        reg_addr_t    src_a;
        reg_addr_t    src_b;
        word_t        imm;
    } decode_entry_t;

    // one issue slot toward execute
    typedef struct packed
    {
        logic         valid;
        word_t        pc;
        instr_class_t iclass;
        logic         regwrite;
        reg_addr_t    dest;
        word_t        imm;
        word_t        op_a;
        word_t        op_b;
    } issue_slot_t;

    // one writeback port into the register file
    typedef struct packed
    {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

    // loads and stores share the single memory port
    function automatic logic is_mem(instr_class_t iclass);
        return (iclass == class_load) || (iclass == class_store);
    endfunction

endpackage

//--- src/issue/issue_queue.sv
`timescale 1ns/1ns

module issue_queue #(
    parameter int queue_depth = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         flush,
    input  logic                         stall,
    input  logic [1:0]                   in_valid,
    input  mips_pkg::decode_entry_t [1:0] in_instr,
    input  logic [1:0]                   issue_count,
    output logic                         in_ready,
    output mips_pkg::decode_entry_t [1:0] head_entry,
    output logic [1:0]                   head_valid
);

    localparam int ptr_w = $clog2(queue_depth);

    typedef logic [ptr_w-1:0] ptr_t;
    typedef logic [ptr_w:0]   count_t;

    localparam count_t depth_level = count_t'(queue_depth);
    localparam count_t ready_level = count_t'(queue_depth - 2);

    mips_pkg::decode_entry_t ring [queue_depth];

    ptr_t   head;
    ptr_t   tail;
    ptr_t   head_next;
    ptr_t   tail_next;
    count_t count;

    logic       push_en;
    logic [1:0] push_n;
    logic [1:0] pop_n;

    // need room for a full pair before decode may send
    assign in_ready = (count <= ready_level);
    assign push_en  = in_ready && !flush;

    assign push_n = push_en ? (2'(in_valid[1]) + 2'(in_valid[0])) : 2'd0;
    assign pop_n  = stall ? 2'd0 : issue_count;

    assign head_next = head + ptr_t'(1);
    // the younger input lands behind the older one when both are present
    assign tail_next = tail + ptr_t'(in_valid[1]);

    assign head_valid[1] = (count != '0);
    assign head_valid[0] = (count > count_t'(1));

    // zero the empty head positions so pairing never sees stale entries
    assign head_entry[1] = head_valid[1] ? ring[head] : '0;
    assign head_entry[0] = head_valid[0] ? ring[head_next] : '0;

    always_ff @(posedge clk)
    begin
        if (push_en && in_valid[1])
        begin
            ring[tail] <= in_instr[1];
        end
        if (push_en && in_valid[0])
        begin
            ring[tail_next] <= in_instr[0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset || flush)
        begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end
        else
        begin
            head  <= head + ptr_t'(pop_n);
            tail  <= tail + ptr_t'(push_n);
            count <= count + count_t'(push_n) - count_t'(pop_n);
        end
    end

    // occupancy stays within the ring
    assert property (@(posedge clk) disable iff (!reset)
        count <= depth_level)
        else $error("issue queue occupancy above depth");

    // pairing never asks for more entries than the head holds
    assert property (@(posedge clk) disable iff (!reset)
        issue_count <= 2'($countones(head_valid)))
        else $error("issue count exceeds valid head entries");

endmodule

//--- src/issue/issue_pairing.sv
`timescale 1ns/1ns

module issue_pairing (
    input  mips_pkg::decode_entry_t [1:0] head_entry,
    input  logic [1:0]                   head_valid,
    output logic [1:0]                   issue_count
);

    mips_pkg::decode_entry_t older;
    mips_pkg::decode_entry_t younger;

    logic raw;
    logic mem_pair;
    logic muldiv_pair;
    logic older_branch;
    logic younger_branch;
    logic blocked;

    assign older   = head_entry[1];
    assign younger = head_entry[0];

    assign raw = older.regwrite && (older.dest != mips_pkg::reg_zero) &&
                 ((older.dest == younger.src_a) || (older.dest == younger.src_b));

    assign mem_pair    = mips_pkg::is_mem(older.iclass) && mips_pkg::is_mem(younger.iclass);
    assign muldiv_pair = (older.iclass == mips_pkg::class_muldiv) &&
                         (younger.iclass == mips_pkg::class_muldiv);

    assign older_branch   = (older.iclass == mips_pkg::class_branch);
    assign younger_branch = (younger.iclass == mips_pkg::class_branch);

    assign blocked = raw || mem_pair || muldiv_pair;

    always_comb
    begin
        if (!head_valid[1])
            issue_count = 2'd0;
        // a branch waits for its delay slot
        else if (older_branch && !head_valid[0])
            issue_count = 2'd0;
        else if (older_branch)
            issue_count = blocked ? 2'd1 : 2'd2;
        else if (!head_valid[0] || blocked || younger_branch)
            issue_count = 2'd1;
        else
            issue_count = 2'd2;
    end

endmodule

//--- src/issue/operand_read.sv
`timescale 1ns/1ns

module operand_read (
    input  mips_pkg::decode_entry_t entry,
    input  logic                    issue,
    input  mips_pkg::word_t         rdata_a,
    input  mips_pkg::word_t         rdata_b,
    output mips_pkg::issue_slot_t   slot
);

    logic use_imm;

    // stores need the register value as their store data
    assign use_imm = (entry.iclass != mips_pkg::class_store) &&
                     (entry.src_b == mips_pkg::reg_zero);

    always_comb
    begin
        slot = '0;
        if (issue)
        begin
            slot.valid    = 1'b1;
            slot.pc       = entry.pc;
            slot.iclass   = entry.iclass;
            slot.regwrite = entry.regwrite;
            slot.dest     = entry.dest;
            slot.imm      = entry.imm;
            slot.op_a     = rdata_a;
            slot.op_b     = use_imm ? entry.imm : rdata_b;
        end
    end

endmodule

//--- src/regfile.sv
`timescale 1ns/1ns

module regfile (
    input  logic                       clk,
    input  logic                       reset,
    input  mips_pkg::reg_addr_t [3:0]  raddr,
    output mips_pkg::word_t [3:0]      rdata,
    input  mips_pkg::reg_write_t [1:0] wr
);

    mips_pkg::word_t regs [31:1];

    logic [1:0] wr_hit;

    assign wr_hit[0] = wr[0].en && (wr[0].addr != mips_pkg::reg_zero);
    assign wr_hit[1] = wr[1].en && (wr[1].addr != mips_pkg::reg_zero);

    // port 1 is written last so it wins on a shared address
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            if (wr_hit[0])
                regs[wr[0].addr] <= wr[0].data;
            if (wr_hit[1])
                regs[wr[1].addr] <= wr[1].data;
        end
    end

    // write-through so a same-cycle write is seen by issue
    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (raddr[i] == mips_pkg::reg_zero)
                rdata[i] = '0;
            else if (wr_hit[1] && (wr[1].addr == raddr[i]))
                rdata[i] = wr[1].data;
            else if (wr_hit[0] && (wr[0].addr == raddr[i]))
                rdata[i] = wr[0].data;
            else
                rdata[i] = regs[raddr[i]];
        end
    end

endmodule

//--- src/issue_stage_top.sv
`timescale 1ns/1ns

module issue_stage_top #(
    parameter int queue_depth = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  logic                          stall,
    input  logic [1:0]                    in_valid,
    input  mips_pkg::decode_entry_t [1:0] in_instr,
    output logic                          in_ready,
    input  mips_pkg::reg_write_t [1:0]    wr,
    output mips_pkg::issue_slot_t [1:0]   out_slot
);

    mips_pkg::decode_entry_t [1:0] head_entry;
    logic [1:0]                    head_valid;
    logic [1:0]                    issue_count;
    logic [1:0]                    issue_en;
    mips_pkg::reg_addr_t [3:0]     raddr;
    mips_pkg::word_t [3:0]         rdata;
    mips_pkg::issue_slot_t [1:0]   slot_next;

    issue_queue #(
        .queue_depth(queue_depth)
    ) u_queue (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .stall      (stall),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .issue_count(issue_count),
        .in_ready   (in_ready),
        .head_entry (head_entry),
        .head_valid (head_valid)
    );

    issue_pairing u_pairing (
        .head_entry (head_entry),
        .head_valid (head_valid),
        .issue_count(issue_count)
    );

    assign issue_en[1] = (issue_count != 2'd0);
    assign issue_en[0] = (issue_count == 2'd2);

    // older entry on the upper two read ports
    assign raddr = {head_entry[1].src_a, head_entry[1].src_b,
                    head_entry[0].src_a, head_entry[0].src_b};

    regfile u_regfile (
        .clk  (clk),
        .reset(reset),
        .raddr(raddr),
        .rdata(rdata),
        .wr   (wr)
    );

    operand_read u_read_older (
        .entry  (head_entry[1]),
        .issue  (issue_en[1]),
        .rdata_a(rdata[3]),
        .rdata_b(rdata[2]),
        .slot   (slot_next[1])
    );

    operand_read u_read_younger (
        .entry  (head_entry[0]),
        .issue  (issue_en[0]),
        .rdata_a(rdata[1]),
        .rdata_b(rdata[0]),
        .slot   (slot_next[0])
    );

    always_ff @(posedge clk)
    begin
        if (!reset || flush)
        begin
            out_slot[1].valid <= 1'b0;
            out_slot[0].valid <= 1'b0;
        end
        else if (!stall)
        begin
            out_slot <= slot_next;
        end
    end

    // the younger slot only ever travels with the older one
    assert property (@(posedge clk) disable iff (!reset)
        !(out_slot[0].valid && !out_slot[1].valid))
        else $error("younger issue slot valid without older slot");

endmodule

//--- bench/issue_stage_tb.sv
`timescale 1ns/1ns

module issue_stage_tb;

    localparam int num_rows  = 24;
    localparam int row_bound = 8;

    localparam mips_pkg::instr_class_t alu = mips_pkg::class_alu;
    localparam mips_pkg::instr_class_t ld  = mips_pkg::class_load;
    localparam mips_pkg::instr_class_t st  = mips_pkg::class_store;
    localparam mips_pkg::instr_class_t br  = mips_pkg::class_branch;
    localparam mips_pkg::instr_class_t md  = mips_pkg::class_muldiv;

    // one step of stimulus and the next issue group expected from it
    typedef struct packed
    {
        logic [1:0]                    valid;
        mips_pkg::decode_entry_t [1:0] instr;
        mips_pkg::reg_write_t [1:0]    wr;
        logic                          stall;
        logic                          flush;
        logic [1:0]                    n;
        mips_pkg::word_t               pc_old;
        mips_pkg::word_t               pc_young;
        logic                          rdy;
    } row_t;

    logic                          clk;
    logic                          reset;
    logic                          flush;
    logic                          stall;
    logic                          in_ready;
    logic [1:0]                    in_valid;
    mips_pkg::decode_entry_t [1:0] in_instr;
    mips_pkg::reg_write_t [1:0]    wr;
    mips_pkg::issue_slot_t [1:0]   out_slot;

    row_t                    rows [num_rows];
    mips_pkg::decode_entry_t sent [mips_pkg::word_t];
    mips_pkg::word_t         model [32];
    int                      nrow;
    int                      errors;
    int                      checks;
    integer                  seed;

    issue_stage_top #(
        .queue_depth(8)
    ) dut_i (
        .clk     (clk),
        .reset   (reset),
        .flush   (flush),
        .stall   (stall),
        .in_valid(in_valid),
        .in_instr(in_instr),
        .in_ready(in_ready),
        .wr      (wr),
        .out_slot(out_slot)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        #(num_rows * 20 * 40);
        $display("watchdog expired before all rows were applied");
        $display("Regression failed");
        $finish;
    end

    function automatic mips_pkg::decode_entry_t make_entry(mips_pkg::word_t pc,
            mips_pkg::instr_class_t cls, logic rw, int dest, int sa, int sb);
        mips_pkg::decode_entry_t e;
        e.pc       = pc;
        e.iclass   = cls;
        e.regwrite = rw;
        e.dest     = 5'(dest);
        e.src_a    = 5'(sa);
        e.src_b    = 5'(sb);
        e.imm      = $random(seed);
        return e;
    endfunction

    function automatic mips_pkg::reg_write_t write_port(int addr, mips_pkg::word_t data);
        mips_pkg::reg_write_t w;
        w.en   = 1'b1;
        w.addr = 5'(addr);
        w.data = data;
        return w;
    endfunction

    task automatic add_row(input logic [1:0] v, input mips_pkg::decode_entry_t o,
            input mips_pkg::decode_entry_t y, input mips_pkg::reg_write_t w0,
            input mips_pkg::reg_write_t w1, input logic stl, input logic fl,
            input logic [1:0] n, input mips_pkg::word_t pco, input mips_pkg::word_t pcy,
            input logic rdy);
        row_t r;
        r.valid    = v;
        r.instr[1] = o;
        r.instr[0] = y;
        r.wr[0]    = w0;
        r.wr[1]    = w1;
        r.stall    = stl;
        r.flush    = fl;
        r.n        = n;
        r.pc_old   = pco;
        r.pc_young = pcy;
        r.rdy      = rdy;
        rows[nrow] = r;
        nrow++;
        if (v[1])
            sent[o.pc] = o;
        if (v[0])
            sent[y.pc] = y;
    endtask

    task automatic drive_idle(input logic stl);
        in_valid <= 2'b00;
        wr       <= '0;
        flush    <= 1'b0;
        stall    <= stl;
    endtask

    // model follows the register file, port 1 applied last
    task automatic drive_row(input row_t r);
        in_valid <= r.valid;
        in_instr <= r.instr;
        wr       <= r.wr;
        stall    <= r.stall;
        flush    <= r.flush;
        for (int p = 0; p < 2; p++)
        begin
            if (r.wr[p].en && r.wr[p].addr != 5'd0)
                model[r.wr[p].addr] = r.wr[p].data;
        end
    endtask

    task automatic check_slot(input mips_pkg::issue_slot_t s);
        mips_pkg::decode_entry_t e;
        mips_pkg::word_t         exp_b;
        checks++;
        if (!sent.exists(s.pc))
        begin
            $display("instruction at pc %h was issued without being expected, or twice", s.pc);
            errors++;
        end
        else
        begin
            e = sent[s.pc];
            sent.delete(s.pc);
            // immediate replaces src_b = 0 except for stores
            exp_b = (e.iclass != st && e.src_b == 5'd0) ? e.imm : model[e.src_b];
            assert (s.op_a == model[e.src_a] && s.op_b == exp_b)
            else
            begin
                $display("[ERROR] %0t: pc %h operands %h %h, expected %h %h", $time,
                         s.pc, s.op_a, s.op_b, model[e.src_a], exp_b);
                errors++;
            end
            assert (s.iclass == e.iclass && s.regwrite == e.regwrite &&
                    s.dest == e.dest && s.imm == e.imm)
            else
            begin
                $display("[ERROR] %0t: pc %h class %0d rw %b dest %0d imm %h, expected %0d %b %0d %h",
                         $time, s.pc, s.iclass, s.regwrite, s.dest, s.imm,
                         e.iclass, e.regwrite, e.dest, e.imm);
                errors++;
            end
        end
    endtask

    task automatic run_row(input int i);
        row_t                        r;
        mips_pkg::issue_slot_t [1:0] held;
        int                          cycles;
        logic [1:0]                  got;
        r = rows[i];
        @(posedge clk);
        drive_row(r);
        @(negedge clk);
        if (r.n == 2'd0)
        begin
            held = out_slot;
            for (int c = 0; c < 3; c++)
            begin
                @(posedge clk);
                drive_idle(r.stall);
                @(negedge clk);
                checks++;
                // a flush only clears the valid bits
                assert (r.flush ? (!out_slot[1].valid && !out_slot[0].valid)
                                : (out_slot == held && (r.stall || !out_slot[1].valid)))
                else
                begin
                    $display("[ERROR] %0t: row %0d out_slot changed, issued or not cleared",
                             $time, i);
                    errors++;
                end
            end
            checks++;
            assert (in_ready == r.rdy)
            else
            begin
                $display("[ERROR] %0t: row %0d in_ready %b, expected %b", $time, i,
                         in_ready, r.rdy);
                errors++;
            end
        end
        else
        begin
            cycles = 0;
            while (!out_slot[1].valid && cycles < row_bound)
            begin
                @(posedge clk);
                drive_idle(r.stall);
                @(negedge clk);
                cycles++;
            end
            if (!out_slot[1].valid)
            begin
                $display("row %0d: nothing was issued within %0d cycles", i, row_bound);
                errors++;
            end
            else
            begin
                got = 2'(out_slot[1].valid) + 2'(out_slot[0].valid);
                checks++;
                assert (got == r.n && out_slot[1].pc == r.pc_old &&
                        (r.n == 2'd1 || out_slot[0].pc == r.pc_young))
                else
                begin
                    $display("[ERROR] %0t: row %0d issued %0d (pc %h %h), expected %0d (pc %h %h)",
                             $time, i, got, out_slot[1].pc, out_slot[0].pc, r.n,
                             r.pc_old, r.pc_young);
                    errors++;
                end
                check_slot(out_slot[1]);
                if (out_slot[0].valid)
                    check_slot(out_slot[0]);
            end
        end
    endtask

    initial
    begin
        seed     = 32'h3564;
        errors   = 0;
        checks   = 0;
        nrow     = 0;
        reset    = 1'b0;
        flush    = 1'b0;
        stall    = 1'b0;
        in_valid = 2'b00;
        in_instr = '0;
        wr       = '0;
        for (int r = 0; r < 32; r++)
            model[r] = '0;

        // independent pair, the younger one takes its immediate
        add_row(2'b11, make_entry(32'h100, alu, 1, 3, 1, 2), make_entry(32'h104, alu, 1, 4, 2, 0),
                write_port(1, 32'h11), write_port(2, 32'h22), 0, 0, 2, 32'h100, 32'h104, 1);
        // RAW on r5
        add_row(2'b11, make_entry(32'h108, alu, 1, 5, 1, 2), make_entry(32'h10c, alu, 1, 6, 5, 1),
                '0, '0, 0, 0, 1, 32'h108, 0, 1);
        add_row(2'b00, '0, '0, '0, '0, 0, 0, 1, 32'h10c, 0, 1);
        // a write to r0 is no hazard
        add_row(2'b11, make_entry(32'h110, alu, 1, 0, 1, 2), make_entry(32'h114, alu, 1, 7, 0, 0),
                '0, '0, 0, 0, 2, 32'h110, 32'h114, 1);
        add_row(2'b11, make_entry(32'h118, ld, 1, 7, 1, 0), make_entry(32'h11c, st, 0, 0, 2, 0),
                '0, '0, 0, 0, 1, 32'h118, 0, 1);
        add_row(2'b00, '0, '0, '0, '0, 0, 0, 1, 32'h11c, 0, 1);
        add_row(2'b11, make_entry(32'h120, md, 0, 0, 1, 2), make_entry(32'h124, md, 0, 0, 2, 1),
                '0, '0, 0, 0, 1, 32'h120, 0, 1);
        add_row(2'b00, '0, '0, '0, '0, 0, 0, 1, 32'h124, 0, 1);
        // the younger branch goes alone, then waits for its delay slot
        add_row(2'b11, make_entry(32'h128, alu, 1, 9, 1, 2), make_entry(32'h12c, br, 0, 0, 1, 2),
                '0, '0, 0, 0, 1, 32'h128, 0, 1);
        add_row(2'b00, '0, '0, '0, '0, 0, 0, 0, 0, 0, 1);
        add_row(2'b10, make_entry(32'h130, alu, 1, 10, 2, 1), '0,
                '0, '0, 0, 0, 2, 32'h12c, 32'h130, 1);
        add_row(2'b11, make_entry(32'h134, br, 0, 0, 1, 2), make_entry(32'h138, alu, 1, 11, 1, 0),
                '0, '0, 0, 0, 2, 32'h134, 32'h138, 1);
        // both ports write r8, port 1 must win
        add_row(2'b11, make_entry(32'h13c, alu, 1, 12, 8, 1), make_entry(32'h140, alu, 1, 13, 8, 0),
                write_port(8, 32'haaaa_0000), write_port(8, 32'h5555_1234), 0, 0,
                2, 32'h13c, 32'h140, 1);
        // fill the queue under stall
        add_row(2'b11, make_entry(32'h144, alu, 1, 20, 1, 2), make_entry(32'h148, alu, 1, 21, 2, 8),
                '0, '0, 1, 0, 0, 0, 0, 1);
        add_row(2'b11, make_entry(32'h14c, alu, 1, 22, 8, 1), make_entry(32'h150, alu, 1, 23, 1, 0),
                '0, '0, 1, 0, 0, 0, 0, 1);
        add_row(2'b11, make_entry(32'h154, alu, 1, 24, 2, 1), make_entry(32'h158, alu, 1, 25, 8, 2),
                '0, '0, 1, 0, 0, 0, 0, 1);
        add_row(2'b11, make_entry(32'h15c, alu, 1, 26, 1, 8), make_entry(32'h160, alu, 1, 27, 2, 0),
                '0, '0, 1, 0, 0, 0, 0, 0);
        add_row(2'b00, '0, '0, '0, '0, 0, 0, 2, 32'h144, 32'h148, 1);
        add_row(2'b00, '0, '0, '0, '0, 0, 0, 2, 32'h14c, 32'h150, 1);
        add_row(2'b00, '0, '0, '0, '0, 0, 0, 2, 32'h154, 32'h158, 1);
        // stall again so the last pair stays in out_slot
        add_row(2'b00, '0, '0, '0, '0, 1, 0, 2, 32'h15c, 32'h160, 1);
        // these two are flushed before they can issue
        add_row(2'b11, make_entry(32'h164, alu, 1, 28, 1, 2), make_entry(32'h168, alu, 1, 29, 2, 1),
                '0, '0, 1, 0, 0, 0, 0, 1);
        add_row(2'b00, '0, '0, '0, '0, 1, 1, 0, 0, 0, 1);
        add_row(2'b11, make_entry(32'h16c, alu, 1, 30, 8, 2), make_entry(32'h170, alu, 1, 31, 1, 0),
                '0, '0, 0, 0, 2, 32'h16c, 32'h170, 1);

        repeat (2) @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < num_rows; i++)
            run_row(i);
        @(posedge clk);
        drive_idle(1'b0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- issue_stage_top.f
common/mips_pkg.sv
src/issue/issue_queue.sv
src/issue/issue_pairing.sv
src/issue/operand_read.sv
src/regfile.sv
src/issue_stage_top.sv
bench/issue_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the issue stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f issue_stage_top.f \
    --top-module issue_stage_tb \
    --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

output=$(./obj_dir/Vissue_stage_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Regression passed" <<< "$output"; then
    exit 0
fi
exit 1
